//--- source/sm83_irq_pkg.sv
package sm83_irq_pkg;

	// Register port select, FF0F and FFFF on the real part
	typedef enum logic {
		REG_IF = 1'b0,	// Interrupt flag register
		REG_IE = 1'b1	// Interrupt enable register
	} irq_reg_e;

	// Dispatcher states
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		SAMPLE = 2'd1,	// Cells load the pending bits at the end of this cycle
		OFFER  = 2'd2	// Vector offered to the CPU core
	} disp_state_e;

	// Vector of source 0 (VBlank)
	localparam logic [15:0] VECTOR_BASE   = 16'h0040;
	// Byte distance between vectors of neighbouring sources
	localparam logic [15:0] VECTOR_STRIDE = 16'd8;

endpackage

//--- source/sm83_irq_regs.sv
`timescale 1ns/100ps
`default_nettype none

module sm83_irq_regs #(
		parameter int NUM_IRQ = 5
	) (
		input  logic                     clk,
		input  logic                     rst_n,
		input  logic                     wr_en,
		input  sm83_irq_pkg::irq_reg_e   reg_sel,
		input  logic [7:0]               wdata,
		input  logic [NUM_IRQ-1:0]       irq_lines,
		input  logic                     ime_set,
		input  logic                     ime_clr,
		input  logic [NUM_IRQ-1:0]       ack,
		output logic [7:0]               rdata,
		output logic [NUM_IRQ-1:0]       pending,
		output logic                     ime
	);

	logic [NUM_IRQ-1:0] ie_q;
	logic [NUM_IRQ-1:0] if_q;
	logic [NUM_IRQ-1:0] if_d;
	logic               ie_wr;
	logic               if_wr;

	assign ie_wr = wr_en && (reg_sel == sm83_irq_pkg::REG_IE);
	assign if_wr = wr_en && (reg_sel == sm83_irq_pkg::REG_IF);

	// Next IF: write data or hold, then request lines, then acknowledge
	always_comb begin
		if (if_wr)
			if_d = wdata[NUM_IRQ-1:0];
		else
			if_d = if_q;
		if_d = if_d | irq_lines;	// A line pulse beats a clearing write
		if_d = if_d & ~ack;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ie_q <= '0;
			if_q <= '0;
		end else begin
			if (ie_wr)
				ie_q <= wdata[NUM_IRQ-1:0];
			if_q <= if_d;
		end
	end

	// Master enable, clear has priority over set
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ime <= 1'b0;
		else if (ime_clr || (|ack))
			ime <= 1'b0;
		else if (ime_set)
			ime <= 1'b1;
	end

	// Read mux, unused upper bits read as zero
	always_comb begin
		rdata = '0;
		case (reg_sel)
			sm83_irq_pkg::REG_IE: rdata[NUM_IRQ-1:0] = ie_q;
			default:              rdata[NUM_IRQ-1:0] = if_q;
		endcase
	end

	assign pending = ie_q & if_q;	// Enabled and flagged

endmodule

`default_nettype wire

//--- source/sm83_irq_prio_bit.sv
`timescale 1ns/100ps
`default_nettype none

// One link of the priority chain
// chain_in high means a higher-priority cell already holds the grant
module sm83_irq_prio_bit (
		input  logic clk,
		input  logic rst_n,
		input  logic sample,
		input  logic req,
		input  logic chain_in,
		output logic grant,
		output logic chain_out
	);

	logic req_q;	// Request snapshot, frozen between samples

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			req_q <= 1'b0;
		else if (sample)
			req_q <= req;
	end

	// Granted only if nobody upstream claimed
	assign grant     = req_q & ~chain_in;
	assign chain_out = req_q | chain_in;	// Block everything below

endmodule

`default_nettype wire

//--- source/sm83_irq_prio_chain.sv
`timescale 1ns/100ps
`default_nettype none

module sm83_irq_prio_chain #(
		parameter int NUM_IRQ = 5
	) (
		input  logic               clk,
		input  logic               rst_n,
		input  logic               sample,
		input  logic [NUM_IRQ-1:0] pending,
		output logic [NUM_IRQ-1:0] grant,
		output logic               any_grant,
		output logic [15:0]        grant_vector
	);

	localparam int IDX_W = (NUM_IRQ > 1) ? $clog2(NUM_IRQ) : 1;

	logic [NUM_IRQ:0]   chain;	// chain[i] is the claim seen by cell i
	logic [IDX_W-1:0]   grant_idx;

	assign chain[0] = 1'b0;	// Nothing above source 0

	for (genvar i = 0; i < NUM_IRQ; i++) begin : g_cell
		sm83_irq_prio_bit sm83_irq_prio_bit_inst (
			.clk       (clk),
			.rst_n     (rst_n),
			.sample    (sample),
			.req       (pending[i]),
			.chain_in  (chain[i]),
			.grant     (grant[i]),
			.chain_out (chain[i+1])
		);
	end

	assign any_grant = chain[NUM_IRQ];

	// Encode the one-hot grant
	always_comb begin
		grant_idx = '0;
		for (int i = 0; i < NUM_IRQ; i++) begin
			if (grant[i])
				grant_idx = IDX_W'(i);
		end
	end

	assign grant_vector = sm83_irq_pkg::VECTOR_BASE
		+ sm83_irq_pkg::VECTOR_STRIDE * 16'(grant_idx);

endmodule

`default_nettype wire

//--- source/sm83_irq_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module sm83_irq_dispatch #(
		parameter int NUM_IRQ = 5
	) (
		input  logic               clk,
		input  logic               rst_n,
		input  logic [NUM_IRQ-1:0] pending,
		input  logic               ime,
		input  logic [NUM_IRQ-1:0] grant,
		input  logic               any_grant,
		input  logic [15:0]        grant_vector,
		input  logic               irq_ready,
		output logic               sample,
		output logic               irq_valid,
		output logic [15:0]        irq_vector,
		output logic [NUM_IRQ-1:0] ack
	);

	sm83_irq_pkg::disp_state_e state_q;
	sm83_irq_pkg::disp_state_e state_d;

	logic xfer;	// Vector taken by the core this cycle
	logic start;

	// Hold off for the ack cycle, IF and IME are not cleared yet
	assign start = ime && (|pending) && !(|ack);

	assign xfer = irq_valid && irq_ready;

	always_comb begin
		state_d = state_q;
		case (state_q)
			sm83_irq_pkg::IDLE: begin
				if (start)
					state_d = sm83_irq_pkg::SAMPLE;
			end
			sm83_irq_pkg::SAMPLE: begin
				state_d = sm83_irq_pkg::OFFER;
			end
			sm83_irq_pkg::OFFER: begin
				// Empty snapshot gives up without an offer
				if (!any_grant || xfer)
					state_d = sm83_irq_pkg::IDLE;
			end
			default: begin
				state_d = sm83_irq_pkg::IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state_q <= sm83_irq_pkg::IDLE;
		else
			state_q <= state_d;
	end

	// The granted bit goes back for one cycle after the transfer
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ack <= '0;
		else if (xfer)
			ack <= grant;
		else
			ack <= '0;
	end

	assign sample = (state_q == sm83_irq_pkg::SAMPLE);

	// Snapshot is frozen, so the vector holds while the core stalls
	assign irq_valid  = (state_q == sm83_irq_pkg::OFFER) && any_grant;
	assign irq_vector = irq_valid ? grant_vector : 16'h0000;

endmodule

`default_nettype wire

//--- source/sm83_irq_top.sv
`timescale 1ns/100ps
`default_nettype none

module sm83_irq_top #(
		parameter int NUM_IRQ = 5
	) (
		input  logic                   clk,
		input  logic                   rst_n,
		input  logic                   wr_en,
		input  sm83_irq_pkg::irq_reg_e reg_sel,
		input  logic [7:0]             wdata,
		output logic [7:0]             rdata,
		input  logic [NUM_IRQ-1:0]     irq_lines,
		input  logic                   ime_set,
		input  logic                   ime_clr,
		output logic                   irq_valid,
		input  logic                   irq_ready,
		output logic [15:0]            irq_vector
	);

	logic [NUM_IRQ-1:0] pending;
	logic               ime;
	logic               sample;
	logic [NUM_IRQ-1:0] grant;
	logic               any_grant;
	logic [15:0]        grant_vector;
	logic [NUM_IRQ-1:0] ack;

	// IE, IF and IME beside the chain
	sm83_irq_regs #(
		.NUM_IRQ (NUM_IRQ)
	) sm83_irq_regs_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.reg_sel   (reg_sel),
		.wdata     (wdata),
		.irq_lines (irq_lines),
		.ime_set   (ime_set),
		.ime_clr   (ime_clr),
		.ack       (ack),
		.rdata     (rdata),
		.pending   (pending),
		.ime       (ime)
	);

	sm83_irq_prio_chain #(
		.NUM_IRQ (NUM_IRQ)
	) sm83_irq_prio_chain_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.sample       (sample),
		.pending      (pending),
		.grant        (grant),
		.any_grant    (any_grant),
		.grant_vector (grant_vector)
	);

	sm83_irq_dispatch #(
		.NUM_IRQ (NUM_IRQ)
	) sm83_irq_dispatch_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.pending      (pending),
		.ime          (ime),
		.grant        (grant),
		.any_grant    (any_grant),
		.grant_vector (grant_vector),
		.irq_ready    (irq_ready),
		.sample       (sample),
		.irq_valid    (irq_valid),
		.irq_vector   (irq_vector),
		.ack          (ack)
	);

endmodule

`default_nettype wire

//--- verif/sm83_irq_checker.sv
`timescale 1ns/100ps

// Handshake properties of the dispatcher
module sm83_irq_checker #(
		parameter int NUM_IRQ = 5
	) (
		input logic               clk,
		input logic               rst_n,
		input logic               irq_valid,
		input logic               irq_ready,
		input logic [15:0]        irq_vector,
		input logic [NUM_IRQ-1:0] ack
	);

	int fail_count;

	initial fail_count = 0;

	// A stalled offer keeps its vector
	valid_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
		irq_valid && !irq_ready |=> irq_valid && $stable(irq_vector))
		else begin
			$error("irq_valid dropped or irq_vector changed before the transfer");
			fail_count++;
		end

	ack_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(ack))
		else begin
			$error("ack has more than one bit set");
			fail_count++;
		end

	// Ack only in the cycle after a transfer
	ack_after_xfer_a: assert property (@(posedge clk) disable iff (!rst_n)
		(|ack) |-> $past(irq_valid && irq_ready))
		else begin
			$error("ack seen without a transfer in the previous cycle");
			fail_count++;
		end

	xfer_gives_ack_a: assert property (@(posedge clk) disable iff (!rst_n)
		irq_valid && irq_ready |=> (|ack))
		else begin
			$error("transfer not followed by ack");
			fail_count++;
		end

	// First cycle out of reset
	reset_quiet_a: assert property (@(posedge clk)
		$rose(rst_n) |-> !irq_valid)
		else begin
			$error("irq_valid high in the first cycle after reset");
			fail_count++;
		end

endmodule

bind sm83_irq_dispatch sm83_irq_checker #(
	.NUM_IRQ (NUM_IRQ)
) sm83_irq_checker_inst (
	.clk        (clk),
	.rst_n      (rst_n),
	.irq_valid  (irq_valid),
	.irq_ready  (irq_ready),
	.irq_vector (irq_vector),
	.ack        (ack)
);

//--- verif/sm83_irq_tb.sv
`timescale 1ns/100ps

module sm83_irq_tb;

	localparam int NUM_IRQ  = 5;
	localparam int NUM_ROWS = 8;
	localparam int TIMEOUT  = 20;	// Cycles allowed for irq_valid to rise

	typedef struct packed {
		logic [NUM_IRQ-1:0] ie;
		logic [NUM_IRQ-1:0] lines;
		logic               rand_lines;
		logic               set_ime;
		logic [3:0]         ready_wait;	// 4'hf draws a random stall
		logic               exp_disp;
	} row_t;

	logic                   clk;
	logic                   rst_n;
	logic                   wr_en;
	sm83_irq_pkg::irq_reg_e reg_sel;
	logic [7:0]             wdata;
	logic [7:0]             rdata;
	logic [NUM_IRQ-1:0]     irq_lines;
	logic                   ime_set;
	logic                   ime_clr;
	logic                   irq_valid;
	logic                   irq_ready;
	logic [15:0]            irq_vector;

	row_t               rows [NUM_ROWS];
	logic [NUM_IRQ-1:0] ie_model;	// Expected IE
	logic [NUM_IRQ-1:0] if_model;	// Expected IF
	integer             seed;
	int                 errors;
	int                 checks;
	int                 tests_run;
	int                 tests_failed;

	sm83_irq_top #(
		.NUM_IRQ (NUM_IRQ)
	) sm83_irq_top_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.reg_sel    (reg_sel),
		.wdata      (wdata),
		.rdata      (rdata),
		.irq_lines  (irq_lines),
		.ime_set    (ime_set),
		.ime_clr    (ime_clr),
		.irq_valid  (irq_valid),
		.irq_ready  (irq_ready),
		.irq_vector (irq_vector)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got %0h, expected %0h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start_err);
		tests_run++;
		if (errors > start_err)
			tests_failed++;
		$display("test %0d %s: %0d error(s)", tests_run, name, errors - start_err);
	endtask

	// Source with the lowest number among the set bits
	function automatic int lowest_index(input logic [NUM_IRQ-1:0] v);
		int idx;
		idx = -1;
		for (int i = NUM_IRQ - 1; i >= 0; i--) begin
			if (v[i])
				idx = i;
		end
		return idx;
	endfunction

	function automatic logic [15:0] expected_vector(input int idx);
		return sm83_irq_pkg::VECTOR_BASE + 16'(idx * 8);	// Vectors sit 8 bytes apart
	endfunction

	task automatic write_reg(input sm83_irq_pkg::irq_reg_e sel, input logic [7:0] data);
		wr_en   = 1'b1;
		reg_sel = sel;
		wdata   = data;
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic read_reg(input sm83_irq_pkg::irq_reg_e sel, output logic [7:0] data);
		reg_sel = sel;
		#1 data = rdata;	// Read mux settles within the low phase
		@(negedge clk);
	endtask

	// Counts edges after the request edge until irq_valid shows
	task automatic wait_valid(output int lat, output bit ok);
		lat = 0;
		ok  = 1'b0;
		for (int i = 0; i < TIMEOUT; i++) begin
			@(posedge clk);
			lat++;
			@(negedge clk);
			if (irq_valid) begin
				ok = 1'b1;
				break;
			end
		end
		if (!ok) begin
			$display("ERROR: irq_valid did not rise within %0d cycles", TIMEOUT);
			errors++;
		end
	endtask

	task automatic expect_quiet(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			@(negedge clk);
			check("irq_valid", irq_valid, 1'b0);
		end
	endtask

	task automatic dispatch(input int ready_wait);
		int                 lat;
		bit                 ok;
		int                 idx;
		logic [15:0]        vec;
		logic [NUM_IRQ-1:0] hp;
		logic [7:0]         rd;
		idx = lowest_index(ie_model & if_model);
		if (idx < 0) begin
			$display("ERROR: no pending source left to dispatch");
			errors++;
			return;
		end
		vec = expected_vector(idx);
		wait_valid(lat, ok);
		if (!ok)
			return;
		check("latency", lat, 2);
		check("irq_vector", irq_vector, vec);
		hp = NUM_IRQ'((1 << idx) - 1);	// Every source above the granted one
		for (int i = 0; i < ready_wait; i++) begin
			irq_lines = (i == 0) ? hp : '0;
			if (i == 0)
				if_model = if_model | hp;
			@(posedge clk);
			@(negedge clk);
			check("irq_valid", irq_valid, 1'b1);
			check("irq_vector", irq_vector, vec);
		end
		irq_lines = '0;
		irq_ready = 1'b1;
		@(posedge clk);	// Transfer edge
		@(negedge clk);
		irq_ready = 1'b0;
		check("irq_valid", irq_valid, 1'b0);
		if_model = if_model & ~(NUM_IRQ'(1) << idx);
		@(posedge clk);	// End of the ack cycle
		@(negedge clk);
		read_reg(sm83_irq_pkg::REG_IF, rd);
		check("IF", rd, {3'b000, if_model});
	endtask

	task automatic run_row(input int n);
		row_t               r;
		logic [NUM_IRQ-1:0] lines;
		logic [31:0]        rnd;
		logic [7:0]         rd;
		int                 rw;
		int                 start_err;
		r         = rows[n];
		start_err = errors;
		lines     = r.lines;
		if (r.rand_lines) begin
			rnd   = $random(seed);
			lines = rnd[NUM_IRQ-1:0];
			if ((lines & r.ie) == '0)
				lines = r.ie;
		end
		rw = r.ready_wait;
		if (r.ready_wait == 4'hf) begin
			rnd = $random(seed);
			rw  = rnd % 6 + 1;
		end
		ime_clr = 1'b1;
		write_reg(sm83_irq_pkg::REG_IF, 8'h00);
		ime_clr = 1'b0;
		write_reg(sm83_irq_pkg::REG_IE, {3'b000, r.ie});
		irq_lines = lines;
		@(negedge clk);
		irq_lines = '0;
		ie_model  = r.ie;
		if_model  = lines;
		ime_set = r.set_ime;
		@(posedge clk);	// Request edge
		@(negedge clk);
		ime_set = 1'b0;
		if (r.exp_disp) begin
			dispatch(rw);
			// IME is clear after each acknowledge so the rest waits for ime_set
			while ((ie_model & if_model) != '0 && errors == start_err) begin
				expect_quiet(10);
				ime_set = 1'b1;
				@(posedge clk);
				@(negedge clk);
				ime_set = 1'b0;
				dispatch(0);
			end
		end else begin
			expect_quiet(10);
			read_reg(sm83_irq_pkg::REG_IF, rd);
			check("IF", rd, {3'b000, if_model});
		end
		report_test($sformatf("row %0d ie %0h lines %0h stall %0d", n, r.ie, lines, rw),
			start_err);
	endtask

	initial begin
		int         start_err;
		logic [7:0] rd;
		seed         = 32'h5b3dac8d;
		errors       = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		rst_n        = 1'b0;
		wr_en        = 1'b0;
		reg_sel      = sm83_irq_pkg::REG_IF;
		wdata        = 8'h00;
		irq_lines    = '0;
		ime_set      = 1'b0;
		ime_clr      = 1'b0;
		irq_ready    = 1'b0;

		// ie, lines, random lines, ime_set, stall, dispatch
		rows[0] = '{5'h1f, 5'h16, 1'b0, 1'b1, 4'd0, 1'b1};	// Priority
		rows[1] = '{5'h1f, 5'h03, 1'b0, 1'b0, 4'd0, 1'b0};	// IME clear
		rows[2] = '{5'h1c, 5'h03, 1'b0, 1'b1, 4'd0, 1'b0};	// IE clear
		rows[3] = '{5'h1f, 5'h10, 1'b0, 1'b1, 4'd5, 1'b1};
		rows[4] = '{5'h1f, 5'h08, 1'b0, 1'b1, 4'hf, 1'b1};
		rows[5] = '{5'h1f, 5'h00, 1'b1, 1'b1, 4'd0, 1'b1};
		rows[6] = '{5'h15, 5'h00, 1'b1, 1'b1, 4'hf, 1'b1};
		rows[7] = '{5'h01, 5'h01, 1'b0, 1'b1, 4'd2, 1'b1};	// Source 0 under stall

		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		start_err = errors;
		check("irq_valid", irq_valid, 1'b0);
		read_reg(sm83_irq_pkg::REG_IE, rd);
		check("IE", rd, 8'h00);
		read_reg(sm83_irq_pkg::REG_IF, rd);
		check("IF", rd, 8'h00);
		report_test("reset state", start_err);

		start_err = errors;
		write_reg(sm83_irq_pkg::REG_IE, 8'hff);
		read_reg(sm83_irq_pkg::REG_IE, rd);
		check("IE", rd, 8'h1f);
		write_reg(sm83_irq_pkg::REG_IF, 8'hff);
		read_reg(sm83_irq_pkg::REG_IF, rd);
		check("IF", rd, 8'h1f);
		irq_lines = 5'h04;	// Line pulse against a clearing write
		write_reg(sm83_irq_pkg::REG_IF, 8'h00);
		irq_lines = '0;
		read_reg(sm83_irq_pkg::REG_IF, rd);
		check("IF", rd, 8'h04);
		write_reg(sm83_irq_pkg::REG_IF, 8'h00);
		write_reg(sm83_irq_pkg::REG_IE, 8'h00);
		report_test("register access", start_err);

		for (int n = 0; n < NUM_ROWS; n++)
			run_row(n);

		errors += sm83_irq_top_inst.sm83_irq_dispatch_inst.sm83_irq_checker_inst.fail_count;
		$display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- sm83_irq_top.f
source/sm83_irq_pkg.sv
source/sm83_irq_regs.sv
source/sm83_irq_prio_bit.sv
source/sm83_irq_prio_chain.sv
source/sm83_irq_dispatch.sv
source/sm83_irq_top.sv
verif/sm83_irq_checker.sv
verif/sm83_irq_tb.sv
